// File: Bender.yml
package:
  name: dma_pgen

sources:
  - files:
      - hdl/dram_pkg.sv
      - hdl/dma_pkt_pkg.sv
      - hdl/dma_ifs.sv
      - hdl/trx_decoder.sv
      - hdl/dma_core.sv
      - hdl/exit_queue.sv
      - hdl/dma_pgen.sv
  - target: test
    include_dirs:
      - verif
    files:
      - verif/dma_pgen_tb.sv

// File: files.f
+incdir+verif
hdl/dram_pkg.sv
hdl/dma_pkt_pkg.sv
hdl/dma_ifs.sv
hdl/trx_decoder.sv
hdl/dma_core.sv
hdl/exit_queue.sv
hdl/dma_pgen.sv
verif/dma_pgen_tb.sv

// File: hdl/dma_core.sv
`timescale 1ns/1ns

module dma_core (
  input  logic clk,
  input  logic rst,
  dec_if.core  dec,
  exq_if.core  exq
);
  import dram_pkg::*;
  import dma_pkt_pkg::*;

  data_t cfr_reg [CFR_NUM];  // Configuration register file

  logic take;    // Item accepted this cycle
  logic is_cfr;  // Held item targets config space
  logic cfr_wr;  // Config write, no packet

  // ==============================
  // Accept and route
  // ==============================
  assign dec.ready = !exq.pfull;  // Queue headroom covers the in-flight entry
  assign take      = dec.valid && dec.ready;
  assign is_cfr    = (dec.range == CFR_RANGE);
  assign cfr_wr    = take && is_cfr && !dec.isrd;

  // DRAM accesses and config reads make an entry
  assign exq.wr = take && (!is_cfr || dec.isrd);

  always_comb begin
    if (is_cfr) begin
      exq.dest = DEST_DREG;
    end else if (dec.isrd) begin
      exq.dest = DEST_RD;
    end else begin
      exq.dest = DEST_WR;
    end
  end

  // Address fields straight from decode
  assign exq.ch  = dec.ch;
  assign exq.bk  = dec.bk;
  assign exq.row = dec.row;
  assign exq.col = dec.col;

  // Read-back carries register value, mask cleared
  assign exq.data = is_cfr ? cfr_reg[dec.cfr_idx] : dec.data;
  assign exq.mask = is_cfr ? '0 : dec.mask;

  // ==============================
  // Config register writes
  // ==============================
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      for (int i = 0; i < CFR_NUM; i++) begin
        cfr_reg[i] <= '0;
      end
    end else if (cfr_wr) begin
      // Byte enables from the host mask
      for (int b = 0; b < MASK_WIDTH; b++) begin
        if (dec.mask[b]) begin
          cfr_reg[dec.cfr_idx][8*b +: 8] <= dec.data[8*b +: 8];
        end
      end
    end
  end

endmodule

// File: hdl/dma_ifs.sv
`timescale 1ns/1ns

// ==============================
// Decoded host transaction
// ==============================
interface dec_if;
  import dram_pkg::*;
  import dma_pkt_pkg::*;

  logic        valid;
  logic        ready;
  addr_range_t range;
  logic        isrd;     // Read flag from host
  ch_addr_t    ch;
  bk_addr_t    bk;
  row_addr_t   row;
  col_addr_t   col;
  cfr_idx_t    cfr_idx;  // Only meaningful in config range
  data_t       data;
  mask_t       mask;

  modport dec  (output valid, range, isrd, ch, bk, row, col, cfr_idx, data, mask,
                input  ready);
  modport core (input  valid, range, isrd, ch, bk, row, col, cfr_idx, data, mask,
                output ready);
endinterface

// ==============================
// Exit queue write side
// ==============================
interface exq_if;
  import dram_pkg::*;
  import dma_pkt_pkg::*;

  logic      wr;
  dest_t     dest;
  ch_addr_t  ch;
  bk_addr_t  bk;
  row_addr_t row;
  col_addr_t col;
  data_t     data;
  mask_t     mask;
  logic      pfull;  // Programmable full, stop writing

  modport core (output wr, dest, ch, bk, row, col, data, mask, input pfull);
  modport que  (input  wr, dest, ch, bk, row, col, data, mask, output pfull);
endinterface

// File: hdl/dma_pgen.sv
`timescale 1ns/1ns

module dma_pgen #(
  parameter int QUE_DEPTH = 8,
  parameter int QUE_PFULL = 5
) (
  input  logic                   clk,
  input  logic                   rst,
  // Host side
  input  logic                   in_valid,
  output logic                   in_ready,
  input  dram_pkg::host_addr_t   in_addr,
  input  dma_pkt_pkg::data_t     in_data,
  input  dma_pkt_pkg::mask_t     in_mask,
  input  logic                   in_isrd,
  // Interconnect
  output logic                   icnt_valid,
  input  logic                   icnt_rdy,
  output dma_pkt_pkg::req_type_t icnt_req_type,
  output dram_pkg::ch_addr_t     icnt_ch,
  output dram_pkg::bk_addr_t     icnt_bk,
  output dram_pkg::row_addr_t    icnt_row,
  output dram_pkg::col_addr_t    icnt_col,
  output dma_pkt_pkg::data_t     icnt_data,
  output dma_pkt_pkg::mask_t     icnt_mask,
  // Ordering engine request port
  output logic                   orde_valid,
  input  logic                   orde_rdy,
  output dram_pkg::ch_addr_t     orde_ch,
  output dram_pkg::bk_addr_t     orde_bk,
  output dram_pkg::row_addr_t    orde_row,
  output dram_pkg::col_addr_t    orde_col,
  // Ordering engine register-data port
  output logic                   dreg_valid,
  input  logic                   dreg_rdy,
  output dma_pkt_pkg::data_t     dreg_data
);

  dec_if dec_bus ();  // Decode to execute
  exq_if exq_bus ();  // Execute to result

  // ==============================
  // Decode stage
  // ==============================
  trx_decoder u_trx_decoder (
    .clk,
    .rst,
    .in_valid,
    .in_ready,
    .in_addr,
    .in_data,
    .in_mask,
    .in_isrd,
    .dec (dec_bus.dec)
  );

  // Execute stage, config registers live here
  dma_core u_dma_core (
    .clk,
    .rst,
    .dec (dec_bus.core),
    .exq (exq_bus.core)
  );

  // ==============================
  // Result stage
  // ==============================
  exit_queue #(
    .QUE_DEPTH (QUE_DEPTH),
    .QUE_PFULL (QUE_PFULL)
  ) u_exit_queue (
    .clk,
    .rst,
    .exq (exq_bus.que),
    .icnt_valid,
    .icnt_rdy,
    .icnt_req_type,
    .icnt_ch,
    .icnt_bk,
    .icnt_row,
    .icnt_col,
    .icnt_data,
    .icnt_mask,
    .orde_valid,
    .orde_rdy,
    .orde_ch,
    .orde_bk,
    .orde_row,
    .orde_col,
    .dreg_valid,
    .dreg_rdy,
    .dreg_data
  );

endmodule

// File: hdl/dma_pkt_pkg.sv
package dma_pkt_pkg;

  // ============================
  // Packet payload
  // ============================
  localparam int DATA_WIDTH = 64;
  localparam int MASK_WIDTH = DATA_WIDTH / 8;  // One bit per byte

  typedef logic [DATA_WIDTH-1:0] data_t;
  typedef logic [MASK_WIDTH-1:0] mask_t;       // 1 = write the byte

  // Address range, picked by the top host address bit
  typedef enum logic {
    DRAM_RANGE = 1'b0,
    CFR_RANGE  = 1'b1
  } addr_range_t;

  typedef enum logic {
    WRITE = 1'b0,
    READ  = 1'b1
  } req_type_t;

  // Exit queue destination
  typedef enum logic [1:0] {
    DEST_WR   = 2'd0,  // Interconnect only
    DEST_RD   = 2'd1,  // Interconnect and ordering engine together
    DEST_DREG = 2'd2   // Ordering engine register-data port
  } dest_t;

endpackage

// File: hdl/dram_pkg.sv
package dram_pkg;

  // ============================
  // Host address map
  // ============================
  localparam int ADDR_WIDTH = 32;
  localparam int CH_WIDTH   = 5;   // 32 channels
  localparam int BK_WIDTH   = 4;   // 16 banks
  localparam int ROW_WIDTH  = 14;
  localparam int COL_WIDTH  = 5;

  // Field LSB positions, 8-byte beat below COL_LSB
  localparam int COL_LSB   = 3;
  localparam int BK_LSB    = 8;
  localparam int ROW_LSB   = 12;
  localparam int CH_LSB    = 26;
  localparam int RANGE_BIT = 31;   // 0 DRAM, 1 config space

  // Config space
  localparam int CFR_IDX_LSB = 3;  // One 64-bit register per beat
  localparam int CFR_NUM     = 4;

  typedef logic [ADDR_WIDTH-1:0]      host_addr_t;
  typedef logic [CH_WIDTH-1:0]        ch_addr_t;
  typedef logic [BK_WIDTH-1:0]        bk_addr_t;
  typedef logic [ROW_WIDTH-1:0]       row_addr_t;
  typedef logic [COL_WIDTH-1:0]       col_addr_t;
  typedef logic [$clog2(CFR_NUM)-1:0] cfr_idx_t;

endpackage

// File: hdl/exit_queue.sv
`timescale 1ns/1ns

module exit_queue #(
  parameter int QUE_DEPTH = 8,  // Power of two
  parameter int QUE_PFULL = 5
) (
  input  logic                   clk,
  input  logic                   rst,
  exq_if.que                     exq,
  // Interconnect
  output logic                   icnt_valid,
  input  logic                   icnt_rdy,
  output dma_pkt_pkg::req_type_t icnt_req_type,
  output dram_pkg::ch_addr_t     icnt_ch,
  output dram_pkg::bk_addr_t     icnt_bk,
  output dram_pkg::row_addr_t    icnt_row,
  output dram_pkg::col_addr_t    icnt_col,
  output dma_pkt_pkg::data_t     icnt_data,
  output dma_pkt_pkg::mask_t     icnt_mask,
  // Ordering engine request port
  output logic                   orde_valid,
  input  logic                   orde_rdy,
  output dram_pkg::ch_addr_t     orde_ch,
  output dram_pkg::bk_addr_t     orde_bk,
  output dram_pkg::row_addr_t    orde_row,
  output dram_pkg::col_addr_t    orde_col,
  // Ordering engine register-data port
  output logic                   dreg_valid,
  input  logic                   dreg_rdy,
  output dma_pkt_pkg::data_t     dreg_data
);
  import dram_pkg::*;
  import dma_pkt_pkg::*;

  localparam int PTR_W = $clog2(QUE_DEPTH);

  // Entry storage, no reset
  dest_t     dest_mem [QUE_DEPTH];
  ch_addr_t  ch_mem   [QUE_DEPTH];
  bk_addr_t  bk_mem   [QUE_DEPTH];
  row_addr_t row_mem  [QUE_DEPTH];
  col_addr_t col_mem  [QUE_DEPTH];
  data_t     data_mem [QUE_DEPTH];
  mask_t     mask_mem [QUE_DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W:0]   count;      // Occupancy, 0..QUE_DEPTH
  logic             empty;
  logic             pop;
  dest_t            head_dest;  // FWFT head

  assign empty     = (count == '0);
  assign exq.pfull = (count >= QUE_PFULL);
  assign head_dest = dest_mem[rd_ptr];

  // ==============================
  // Write side
  // ==============================
  always_ff @(posedge clk) begin
    if (exq.wr) begin
      dest_mem[wr_ptr] <= exq.dest;
      ch_mem[wr_ptr]   <= exq.ch;
      bk_mem[wr_ptr]   <= exq.bk;
      row_mem[wr_ptr]  <= exq.row;
      col_mem[wr_ptr]  <= exq.col;
      data_mem[wr_ptr] <= exq.data;
      mask_mem[wr_ptr] <= exq.mask;
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (exq.wr) wr_ptr <= wr_ptr + 1'b1;  // Wraps, power-of-two depth
      if (pop)    rd_ptr <= rd_ptr + 1'b1;
      case ({exq.wr, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;           // Both or neither
      endcase
    end
  end

  // ==============================
  // Three-way dispatch
  // ==============================
  // Reads leave on both outlets in the same cycle
  assign icnt_valid = !empty && ((head_dest == DEST_WR) ||
                                 (head_dest == DEST_RD && orde_rdy));
  assign orde_valid = !empty && (head_dest == DEST_RD) && icnt_rdy;
  assign dreg_valid = !empty && (head_dest == DEST_DREG);

  always_comb begin
    case (head_dest)
      DEST_WR:   pop = !empty && icnt_rdy;
      DEST_RD:   pop = !empty && icnt_rdy && orde_rdy;
      DEST_DREG: pop = !empty && dreg_rdy;
      default:   pop = 1'b0;  // Never written
    endcase
  end

  // Head fields fanned out to every outlet
  assign icnt_req_type = (head_dest == DEST_RD) ? READ : WRITE;
  assign icnt_ch       = ch_mem[rd_ptr];
  assign icnt_bk       = bk_mem[rd_ptr];
  assign icnt_row      = row_mem[rd_ptr];
  assign icnt_col      = col_mem[rd_ptr];
  assign icnt_data     = data_mem[rd_ptr];
  assign icnt_mask     = mask_mem[rd_ptr];
  assign orde_ch       = ch_mem[rd_ptr];
  assign orde_bk       = bk_mem[rd_ptr];
  assign orde_row      = row_mem[rd_ptr];
  assign orde_col      = col_mem[rd_ptr];
  assign dreg_data     = data_mem[rd_ptr];  // Config read-back value

endmodule

// File: hdl/trx_decoder.sv
`timescale 1ns/1ns

module trx_decoder (
  input  logic                clk,
  input  logic                rst,
  input  logic                in_valid,
  output logic                in_ready,
  input  dram_pkg::host_addr_t in_addr,
  input  dma_pkt_pkg::data_t  in_data,
  input  dma_pkt_pkg::mask_t  in_mask,
  input  logic                in_isrd,
  dec_if.dec                  dec
);
  import dram_pkg::*;
  import dma_pkt_pkg::*;

  logic init_done;  // Holds off the host for one cycle after reset
  logic load;       // Host handshake

  // Refill allowed while the core takes the held item
  assign in_ready = init_done && (!dec.valid || dec.ready);
  assign load     = in_valid && in_ready;

  // ==============================
  // Holding register control
  // ==============================
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      init_done <= 1'b0;
      dec.valid <= 1'b0;
    end else begin
      init_done <= 1'b1;
      if (load) begin
        dec.valid <= 1'b1;
      end else if (dec.ready) begin
        dec.valid <= 1'b0;  // Taken, nothing new
      end
    end
  end

  // Address split on load, fixed map
  always_ff @(posedge clk) begin
    if (load) begin
      dec.range   <= addr_range_t'(in_addr[RANGE_BIT]);
      dec.ch      <= in_addr[CH_LSB +: $bits(ch_addr_t)];
      dec.bk      <= in_addr[BK_LSB +: $bits(bk_addr_t)];
      dec.row     <= in_addr[ROW_LSB +: $bits(row_addr_t)];
      dec.col     <= in_addr[COL_LSB +: $bits(col_addr_t)];
      dec.cfr_idx <= in_addr[CFR_IDX_LSB +: $bits(cfr_idx_t)];  // Overlaps column bits
      dec.isrd    <= in_isrd;
      dec.data    <= in_data;
      dec.mask    <= in_mask;
    end
  end

endmodule

// File: verif/dma_pgen_model.svh
// ==============================
// Reference model
// ==============================
// Expected entries, one queue per outlet
logic [100:0] exp_icnt [$];  // {req_type, ch, bk, row, col, data, mask}
logic [27:0]  exp_orde [$];  // {ch, bk, row, col}
logic [63:0]  exp_dreg [$];  // Register read-back value
logic [63:0]  cfr_model [4]; // Mirror of the config registers

task automatic clear_model();
  for (int i = 0; i < 4; i++) begin
    cfr_model[i] = '0;  // Registers come out of reset as zero
  end
endtask

// One accepted host transaction, in acceptance order
task automatic accept_trx(input logic [31:0] addr, input logic [63:0] data,
                          input logic [7:0] mask, input logic isrd);
  logic [27:0] loc;
  logic [1:0]  idx;
  loc = {addr[30:26], addr[11:8], addr[25:12], addr[7:3]};  // ch, bk, row, col
  idx = addr[4:3];                                            // Register index
  if (!addr[31]) begin
    exp_icnt.push_back({isrd, loc, data, mask});
    if (isrd) begin
      exp_orde.push_back(loc);  // Reads also go to the ordering engine
    end
  end else if (isrd) begin
    exp_dreg.push_back(cfr_model[idx]);
  end else begin
    for (int b = 0; b < 8; b++) begin
      if (mask[b]) begin
        cfr_model[idx][8*b +: 8] = data[8*b +: 8];  // Unmasked bytes kept
      end
    end
  end
endtask

// File: verif/dma_pgen_tb.sv
`timescale 1ns/1ns

module dma_pgen_tb;

  localparam int NUM_TRX      = 400;
  localparam int MAX_CYCLE    = NUM_TRX * 20;  // Cycle budget for the whole run
  localparam int DRAIN_CYCLES = 200;           // Queue plus pipeline under ready drops

  logic         clk = 1'b0;
  logic         rst;
  logic         in_valid, in_ready, in_isrd;
  logic [31:0]  in_addr;
  logic [63:0]  in_data;
  logic [7:0]   in_mask;
  logic         icnt_valid, icnt_rdy, icnt_req_type;
  logic [4:0]   icnt_ch, icnt_col, orde_ch, orde_col;
  logic [3:0]   icnt_bk, orde_bk;
  logic [13:0]  icnt_row, orde_row;
  logic [63:0]  icnt_data, dreg_data;
  logic [7:0]   icnt_mask;
  logic         orde_valid, orde_rdy, dreg_valid, dreg_rdy;
  logic         icnt_fire, orde_fire, dreg_fire;  // Transfers at the coming edge
  logic [31:0]  lfsr_state = 32'h2cbd_5cb5;
  int           cycles, value_errs, proto_errs;

  `include "dma_pgen_model.svh"

  dma_pgen #(.QUE_DEPTH(8), .QUE_PFULL(5)) UUT (.*);

  always #4 clk = ~clk;  // 8 ns period

  // ==============================
  // Random source
  // ==============================
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // x^32+x^22+x^2+x+1
  endfunction

  function automatic logic [63:0] next_bits(input int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_step(lfsr_state);  // One step per bit
      v = {v[62:0], lfsr_state[0]};
    end
    return v;
  endfunction

  task automatic compare_entry(input string name, input logic [127:0] exp,
                               input logic [127:0] act);
    assert (act === exp) else begin
      $display("[FAIL] %s expected %h actual %h", name, exp, act);
      value_errs++;
    end
  endtask

  task automatic report_extra(input string outlet);
    $display("%s transferred an entry that was never sent", outlet);
    proto_errs++;
  endtask

  // Advance one cycle, new outlet readies just after the edge
  task automatic next_cycle();
    @(posedge clk);
    #1;
    icnt_rdy = (next_bits(4) >= 5);  // Low about 30 percent
    orde_rdy = (next_bits(4) >= 5);
    dreg_rdy = (next_bits(4) >= 5);
  endtask

  task automatic send_trx(input logic [31:0] addr, input logic [63:0] data,
                          input logic [7:0] mask, input logic isrd);
    logic taken;
    in_valid = 1'b1;
    in_addr  = addr;
    in_data  = data;
    in_mask  = mask;
    in_isrd  = isrd;
    taken    = 1'b0;
    while (!taken) begin
      @(negedge clk);
      taken = in_ready;  // Handshake at the next edge
      next_cycle();
    end
    in_valid = 1'b0;
  endtask

  // ==============================
  // Monitor, sampled mid-cycle
  // ==============================
  always @(negedge clk) begin
    if (rst) begin
      assert (!icnt_valid && !orde_valid && !dreg_valid) else begin
        $display("An outlet valid is high during reset");
        proto_errs++;
      end
    end else begin
      icnt_fire = icnt_valid && icnt_rdy;
      orde_fire = orde_valid && orde_rdy;
      dreg_fire = dreg_valid && dreg_rdy;
      if (in_valid && in_ready) begin
        accept_trx(in_addr, in_data, in_mask, in_isrd);
      end
      // Reads must leave on both ports in one cycle
      assert ((icnt_fire && icnt_req_type == 1'b1) == orde_fire) else begin
        $display("Read did not transfer on interconnect and ordering port together");
        proto_errs++;
      end
      if (icnt_fire) begin
        assert (exp_icnt.size() > 0) else report_extra("Interconnect");
        if (exp_icnt.size() > 0) begin
          compare_entry("icnt_entry", exp_icnt.pop_front(), {icnt_req_type, icnt_ch,
                        icnt_bk, icnt_row, icnt_col, icnt_data, icnt_mask});
        end
      end
      if (orde_fire) begin
        assert (exp_orde.size() > 0) else report_extra("Ordering request port");
        if (exp_orde.size() > 0) begin
          compare_entry("orde_entry", exp_orde.pop_front(),
                        {orde_ch, orde_bk, orde_row, orde_col});
        end
      end
      if (dreg_fire) begin
        assert (exp_dreg.size() > 0) else report_extra("Register-data port");
        if (exp_dreg.size() > 0) begin
          compare_entry("dreg_read", exp_dreg.pop_front(), dreg_data);
        end
      end
    end
  end

  // Run limit
  always @(posedge clk) begin
    cycles++;
    if (cycles >= MAX_CYCLE) begin
      $display("Timeout after %0d cycles with entries still expected", cycles);
      $display("Simulation failed");
      $finish;
    end
  end

  // ==============================
  // Stimulus
  // ==============================
  initial begin
    logic [31:0] addr;
    logic [63:0] data;
    logic [7:0]  mask;
    logic        isrd;
    int          drain;
    rst        = 1'b1;
    in_valid   = 1'b0;
    in_addr    = '0;
    in_data    = '0;
    in_mask    = '0;
    in_isrd    = 1'b0;
    icnt_rdy   = 1'b1;
    orde_rdy   = 1'b1;
    dreg_rdy   = 1'b1;
    cycles     = 0;
    value_errs = 0;
    proto_errs = 0;
    clear_model();
    repeat (10) @(posedge clk);
    #1;
    rst = 1'b0;
    for (int i = 0; i < 4; i++) begin
      send_trx(32'h8000_0000 | (i << 3), '0, '0, 1'b1);  // Unwritten registers
    end
    for (int n = 0; n < NUM_TRX; n++) begin
      addr     = 32'(next_bits(32));
      addr[31] = (next_bits(2) == 64'd3);  // About a quarter config space
      data     = next_bits(64);
      mask     = 8'(next_bits(8));
      isrd     = 1'(next_bits(1));
      send_trx(addr, data, mask, isrd);
    end
    drain = 0;
    while (exp_icnt.size() + exp_orde.size() + exp_dreg.size() > 0 &&
           drain < DRAIN_CYCLES) begin
      next_cycle();  // Drain what is still in flight
      drain++;
    end
    repeat (20) next_cycle();  // Catch late duplicates
    assert (exp_icnt.size() + exp_orde.size() + exp_dreg.size() == 0) else begin
      $display("Expected entries left over at the end");
      proto_errs++;
    end
    $display("Errors: %0d value, %0d protocol", value_errs, proto_errs);
    if (value_errs + proto_errs == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule
